/* build.f */
+incdir+hw
hw/eeprom_txn_pkg.sv
hw/i2c_bus_pkg.sv
hw/eeprom_txn_seq.sv
hw/i2c_byte_shifter.sv
hw/i2c_bit_timer.sv
hw/eeprom_i2c_master.sv
tests/eeprom_slave_model.sv
tests/tb_eeprom_master.sv

/* hw/eeprom_i2c_master.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_i2c_master
    import eeprom_txn_pkg::*;
    import i2c_bus_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wr_data,
    output logic [7:0]            rd_data,
    output logic                  ack,
    output logic                  error,
    output logic                  busy,
    output logic                  scl,
    output logic                  sda_low,
    input  logic                  sda_in
);

    // sequencer to shifter
    logic       bop_go;
    byte_op_t   bop;
    logic [7:0] bop_byte;
    logic       bop_done;
    logic       bop_nack;
    logic [7:0] rx_byte;

    // shifter to bit timer
    logic     sym_go;
    bus_sym_t sym;
    logic     sym_done;
    logic     sym_bit;

    eeprom_txn_seq u_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .bop_go   (bop_go),
        .bop      (bop),
        .bop_byte (bop_byte),
        .bop_done (bop_done),
        .bop_nack (bop_nack),
        .rx_byte  (rx_byte),
        .rd_data  (rd_data),
        .ack      (ack),
        .error    (error),
        .busy     (busy)
    );

    i2c_byte_shifter u_shifter (
        .CLK      (CLK),
        .RESET    (RESET),
        .bop_go   (bop_go),
        .bop      (bop),
        .bop_byte (bop_byte),
        .bop_done (bop_done),
        .bop_nack (bop_nack),
        .rx_byte  (rx_byte),
        .sym_go   (sym_go),
        .sym      (sym),
        .sym_done (sym_done),
        .sym_bit  (sym_bit)
    );

    i2c_bit_timer u_timer (
        .CLK      (CLK),
        .RESET    (RESET),
        .sym_go   (sym_go),
        .sym      (sym),
        .sym_done (sym_done),
        .sym_bit  (sym_bit),
        .scl      (scl),
        .sda_low  (sda_low),
        .sda_in   (sda_in)
    );

endmodule

/* hw/eeprom_settings.svh */
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// system clocks per quarter scl period, 2 or more
`define SCL_QUARTER 4

// 24C16 geometry, 2048 bytes
`define EE_ADDR_W 11

// device type code in the control byte
`define EE_DEV_ID 4'b1010

`endif

/* hw/eeprom_txn_pkg.sv */
package eeprom_txn_pkg;

    typedef enum logic {
        KIND_WRITE,
        KIND_READ
    } txn_kind_t;

    // sequencer walks these in order, SEQ_STOP also taken on any nack
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_CTRL_W,
        SEQ_ADDR,
        SEQ_DATA,
        SEQ_CTRL_R,
        SEQ_READ,
        SEQ_STOP,
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        BOP_START_WRITE, // start, then send byte
        BOP_WRITE,
        BOP_READ_LAST,   // receive byte, answer nack
        BOP_STOP
    } byte_op_t;

endpackage

/* hw/eeprom_txn_seq.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module eeprom_txn_seq
    import eeprom_txn_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [7:0]            wr_data,
    output logic                  bop_go,
    output byte_op_t              bop,
    output logic [7:0]            bop_byte,
    input  logic                  bop_done,
    input  logic                  bop_nack,
    input  logic [7:0]            rx_byte,
    output logic [7:0]            rd_data,
    output logic                  ack,
    output logic                  error,
    output logic                  busy
);

    seq_state_t state;
    txn_kind_t kind;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [7:0] data_q;
    logic err;

    // 1010, block bits, r/w
    function automatic logic [7:0] ctrl_byte(input logic [`EE_ADDR_W-1:8] hi, input logic rnw);
        ctrl_byte = {`EE_DEV_ID, hi, rnw};
    endfunction

    assign ack   = (state == SEQ_DONE);
    assign error = ack && err;
    assign busy  = (state != SEQ_IDLE) && (state != SEQ_DONE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= SEQ_IDLE;
            bop_go <= 1'b0;
            err    <= 1'b0;
        end
        else
        begin
            bop_go <= 1'b0;
            case (state)
                SEQ_IDLE, SEQ_DONE:
                begin
                    if (wr || rd)
                    begin
                        bop_go   <= 1'b1;
                        bop      <= BOP_START_WRITE;
                        bop_byte <= ctrl_byte(addr[`EE_ADDR_W-1:8], 1'b0);
                        err      <= 1'b0;
                        state    <= SEQ_CTRL_W;
                    end
                    else
                        state <= SEQ_IDLE;
                end
                SEQ_CTRL_W:
                    if (bop_done)
                    begin
                        bop_go <= 1'b1;
                        if (bop_nack)
                        begin
                            bop   <= BOP_STOP;
                            err   <= 1'b1;
                            state <= SEQ_STOP;
                        end
                        else
                        begin
                            bop      <= BOP_WRITE;
                            bop_byte <= addr_q[7:0];
                            state    <= SEQ_ADDR;
                        end
                    end
                SEQ_ADDR:
                    if (bop_done)
                    begin
                        bop_go <= 1'b1;
                        if (bop_nack)
                        begin
                            bop   <= BOP_STOP;
                            err   <= 1'b1;
                            state <= SEQ_STOP;
                        end
                        else if (kind == KIND_WRITE)
                        begin
                            bop      <= BOP_WRITE;
                            bop_byte <= data_q;
                            state    <= SEQ_DATA;
                        end
                        else
                        begin
                            bop      <= BOP_START_WRITE; // repeated start
                            bop_byte <= ctrl_byte(addr_q[`EE_ADDR_W-1:8], 1'b1);
                            state    <= SEQ_CTRL_R;
                        end
                    end
                SEQ_DATA:
                    if (bop_done)
                    begin
                        bop_go <= 1'b1;
                        bop    <= BOP_STOP;
                        err    <= bop_nack;
                        state  <= SEQ_STOP;
                    end
                SEQ_CTRL_R:
                    if (bop_done)
                    begin
                        bop_go <= 1'b1;
                        if (bop_nack)
                        begin
                            bop   <= BOP_STOP;
                            err   <= 1'b1;
                            state <= SEQ_STOP;
                        end
                        else
                        begin
                            bop   <= BOP_READ_LAST;
                            state <= SEQ_READ;
                        end
                    end
                SEQ_READ:
                    if (bop_done)
                    begin
                        bop_go <= 1'b1;
                        bop    <= BOP_STOP;
                        state  <= SEQ_STOP;
                    end
                SEQ_STOP:
                    if (bop_done)
                        state <= SEQ_DONE;
                default:
                    state <= SEQ_IDLE;
            endcase
        end
    end

    // request capture and read result
    always_ff @(posedge CLK)
    begin
        if ((state == SEQ_IDLE || state == SEQ_DONE) && (wr || rd))
        begin
            kind   <= wr ? KIND_WRITE : KIND_READ; // write wins
            addr_q <= addr;
            data_q <= wr_data;
        end
        if (state == SEQ_READ && bop_done)
            rd_data <= rx_byte;
    end

    // ack only closes a transaction that was running
    assert property (@(posedge CLK) disable iff (RESET) $rose(ack) |-> $past(busy))
        else $error("ack without a transaction in progress");

endmodule

/* hw/i2c_bit_timer.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module i2c_bit_timer
    import i2c_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     sym_go,
    input  bus_sym_t sym,
    output logic     sym_done,
    output logic     sym_bit,
    output logic     scl,
    output logic     sda_low,
    input  logic     sda_in
);

    localparam int CW = (`SCL_QUARTER > 2) ? $clog2(`SCL_QUARTER) : 1;
    localparam logic [CW-1:0] LAST = CW'(`SCL_QUARTER - 1);

    bit_phase_t phase;
    bus_sym_t cur_sym;
    logic [CW-1:0] cnt;
    logic q_end;

    assign q_end    = (cnt == LAST);
    assign sym_done = (phase == Q3) && q_end;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase   <= Q_IDLE;
            cnt     <= '0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            if (phase != Q_IDLE)
                cnt <= q_end ? '0 : cnt + 1'b1;
            case (phase)
                Q_IDLE:
                    if (sym_go)
                    begin
                        phase <= Q0;
                        scl   <= 1'b0;
                    end
                Q0:
                begin
                    // data moves one clock after scl falls
                    if (cnt == '0)
                        sda_low <= (cur_sym == SYM_ZERO) || (cur_sym == SYM_STOP);
                    if (q_end)
                        phase <= Q1;
                end
                Q1:
                    if (q_end)
                    begin
                        phase <= Q2;
                        scl   <= 1'b1;
                    end
                Q2:
                begin
                    if (cnt == '0 && cur_sym == SYM_START)
                        sda_low <= 1'b1; // start, sda falls with scl high
                    if (q_end)
                    begin
                        phase <= Q3;
                        if (cur_sym == SYM_STOP)
                            sda_low <= 1'b0;
                    end
                end
                Q3:
                    if (q_end)
                        phase <= Q_IDLE;
                default:
                    phase <= Q_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (phase == Q_IDLE && sym_go)
            cur_sym <= sym;
        if (phase == Q2 && q_end)
            sym_bit <= sda_in; // start of Q3, mid scl high
    end

    property sda_steady_while_scl_high;
        @(posedge CLK) disable iff (RESET)
            $changed(sda_low) |->
                (!scl && phase != Q_IDLE) || cur_sym == SYM_START || cur_sym == SYM_STOP;
    endproperty

    assert property (sda_steady_while_scl_high)
        else $error("sda moved while scl high outside start/stop");

endmodule

/* hw/i2c_bus_pkg.sv */
package i2c_bus_pkg;

    typedef enum logic [2:0] {
        SYM_START,
        SYM_STOP,
        SYM_ZERO,
        SYM_ONE,
        SYM_RECV  // release sda and sample
    } bus_sym_t;

    // scl low in Q0/Q1, high in Q2/Q3 and idle
    typedef enum logic [2:0] {
        Q0,
        Q1,
        Q2,
        Q3,
        Q_IDLE
    } bit_phase_t;

endpackage

/* hw/i2c_byte_shifter.sv */
`timescale 1ns/1ps

module i2c_byte_shifter
    import eeprom_txn_pkg::*;
    import i2c_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       bop_go,
    input  byte_op_t   bop,
    input  logic [7:0] bop_byte,
    output logic       bop_done,
    output logic       bop_nack,
    output logic [7:0] rx_byte,
    output logic       sym_go,
    output bus_sym_t   sym,
    input  logic       sym_done,
    input  logic       sym_bit
);

    byte_op_t op;
    logic active;
    logic [7:0] sh;
    logic [3:0] bit_cnt; // 0..7 data, 8 ack slot

    function automatic bus_sym_t data_sym(input byte_op_t o, input logic b);
        if (o == BOP_READ_LAST)
            data_sym = SYM_RECV;
        else if (b)
            data_sym = SYM_ONE;
        else
            data_sym = SYM_ZERO;
    endfunction

    assign rx_byte = sh;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            sym_go   <= 1'b0;
            bop_done <= 1'b0;
            bit_cnt  <= 4'd0;
        end
        else
        begin
            sym_go   <= 1'b0;
            bop_done <= 1'b0;
            if (bop_go)
            begin
                active  <= 1'b1;
                bit_cnt <= 4'd0;
                sym_go  <= 1'b1;
                case (bop)
                    BOP_START_WRITE: sym <= SYM_START;
                    BOP_STOP:        sym <= SYM_STOP;
                    default:         sym <= data_sym(bop, bop_byte[7]);
                endcase
            end
            else if (active && sym_done)
            begin
                if (sym == SYM_STOP || bit_cnt == 4'd8)
                begin
                    active   <= 1'b0;
                    bop_done <= 1'b1;
                end
                else if (sym == SYM_START)
                begin
                    sym_go <= 1'b1;
                    sym    <= data_sym(op, sh[7]);
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    sym_go  <= 1'b1;
                    if (bit_cnt == 4'd7)
                        sym <= (op == BOP_READ_LAST) ? SYM_ONE : SYM_RECV; // ack slot
                    else
                        sym <= data_sym(op, sh[6]);
                end
            end
        end
    end

    // msb first, sampled bit shifts in from the right
    always_ff @(posedge CLK)
    begin
        if (bop_go)
        begin
            op <= bop;
            sh <= bop_byte;
        end
        else if (active && sym_done)
        begin
            if (sym != SYM_START && sym != SYM_STOP && bit_cnt < 4'd8)
                sh <= {sh[6:0], sym_bit};
            bop_nack <= (bit_cnt == 4'd8) && (op != BOP_READ_LAST) && sym_bit;
        end
    end

    // sequencer must wait for bop_done
    assert property (@(posedge CLK) disable iff (RESET) bop_go |-> !active)
        else $error("byte operation issued while another is in flight");

endmodule

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run, exit status follows the testbench
verilator --binary --timing --assert --top-module tb_eeprom_master -f build.f \
    && ./obj_dir/Vtb_eeprom_master \
    || exit 1

/* tests/eeprom_slave_model.sv */
`timescale 1ns/1ps

module eeprom_slave_model (
    input  logic        CLK,
    input  logic        scl,
    input  logic        sda,
    input  logic        refuse,
    output logic        sda_low,
    output int          stop_count,
    input  logic [10:0] peek_addr,
    output logic [7:0]  peek_data
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_TX,
        M_IGNORE
    } slave_mode_t;

    logic [7:0] mem [2048];
    slave_mode_t mode;
    slave_mode_t next_mode;
    logic scl_q;
    logic sda_q;
    logic [7:0] sh;
    logic [3:0] bits;
    logic acking;
    logic give_ack;
    logic [10:0] ptr;

    assign peek_data = mem[peek_addr];

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = a[7:0] ^ 8'h5a;
        mode       = M_IDLE;
        next_mode  = M_IDLE;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        sh         = 8'h00;
        bits       = 4'd0;
        acking     = 1'b0;
        ptr        = 11'd0;
        sda_low    = 1'b0;
        stop_count = 0;
    end

    // bus sampled on the system clock, edges found from the previous sample
    always @(posedge CLK)
    begin
        if (scl_q && scl && sda_q && !sda)
        begin
            mode = M_CTRL; // start or repeated start
            bits = 4'd0;
            acking = 1'b0;
            sda_low <= 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            stop_count <= stop_count + 1;
            mode = M_IDLE;
            acking = 1'b0;
            sda_low <= 1'b0;
        end
        else if (!scl_q && scl)
        begin
            if (!acking && bits < 4'd8 && (mode == M_CTRL || mode == M_ADDR || mode == M_WDATA))
            begin
                sh = {sh[6:0], sda};
                bits = bits + 4'd1;
            end
            else if (mode == M_TX)
            begin
                if (bits < 4'd8)
                    bits = bits + 4'd1;
                else
                    mode = M_IGNORE; // master nack ends the read
            end
        end
        else if (scl_q && !scl)
        begin
            if (acking)
            begin
                acking = 1'b0;
                bits = 4'd0;
                mode = next_mode;
                sda_low <= (mode == M_TX) ? !mem[ptr][7] : 1'b0;
            end
            else if (bits == 4'd8 && (mode == M_CTRL || mode == M_ADDR || mode == M_WDATA))
            begin
                give_ack = 1'b1;
                case (mode)
                    M_CTRL:
                        if (refuse || sh[7:4] != 4'b1010)
                            give_ack = 1'b0;
                        else
                        begin
                            ptr = {sh[3:1], ptr[7:0]};
                            next_mode = sh[0] ? M_TX : M_ADDR;
                        end
                    M_ADDR:
                    begin
                        ptr = {ptr[10:8], sh};
                        next_mode = M_WDATA;
                    end
                    default:
                    begin
                        mem[ptr] = sh;
                        next_mode = M_IGNORE; // no page writes
                    end
                endcase
                acking = give_ack;
                if (!give_ack)
                    mode = M_IGNORE;
                sda_low <= give_ack;
            end
            else if (mode == M_TX)
                sda_low <= (bits < 4'd8) ? !mem[ptr][3'd7 - bits[2:0]] : 1'b0;
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* tests/eeprom_tests.txt */
# name op addr(hex) data(hex or LCG) refuse
# op WR write, RD read, WB write with a second wr strobe during busy
w_basic WR 123 a5 0
r_basic RD 123 00 0
r_init RD 7f0 00 0
r_init2 RD 00c 00 0
w_blk0 WR 045 11 0
w_blk5 WR 545 ee 0
r_blk0 RD 045 00 0
r_blk5 RD 545 00 0
r_blk3 RD 345 00 0
w_refuse WR 200 3c 1
r_refuse RD 200 00 0
r_nack RD 201 00 1
w_busy WB 333 c3 0
r_busy RD 333 00 0
r_busy2 RD 332 00 0
w_lcg0 WR 6ff LCG 0
r_lcg0 RD 6ff 00 0
w_lcg1 WR 1a0 LCG 0
r_lcg1 RD 1a0 00 0
w_zero WR 000 00 0
r_zero RD 000 00 0
w_top WR 7ff ff 0
r_top RD 7ff 00 0

/* tests/tb_eeprom_master.sv */
`timescale 1ns/1ps
`include "eeprom_settings.svh"

module tb_eeprom_master;

    typedef logic [127:0] word_t;

    localparam word_t OP_WR = word_t'("WR");
    localparam word_t OP_RD = word_t'("RD");
    localparam word_t OP_WB = word_t'("WB");
    localparam word_t W_LCG = word_t'("LCG");
    localparam word_t W_HASH = word_t'("#");

    logic CLK;
    logic RESET;
    logic wr;
    logic rd;
    logic [10:0] addr;
    logic [7:0] wr_data;
    logic [7:0] rd_data;
    logic ack;
    logic error;
    logic busy;
    logic scl;
    logic sda_low_m;
    logic sda_low_s;
    logic refuse;
    logic [10:0] peek_addr;
    logic [7:0] peek_data;
    int stop_count;
    wire sda = !(sda_low_m || sda_low_s); // wired-AND

    word_t t_name [64];
    word_t t_op [64];
    logic [10:0] t_addr [64];
    logic [7:0] t_data [64];
    logic t_lcg [64];
    logic t_ref [64];
    logic [7:0] shadow [2048];
    int n_tests;
    int accepted;
    int cycles;
    int limit;
    logic [31:0] lcg_state;

    eeprom_i2c_master UUT (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .error   (error),
        .busy    (busy),
        .scl     (scl),
        .sda_low (sda_low_m),
        .sda_in  (sda)
    );

    eeprom_slave_model slave (
        .CLK        (CLK),
        .scl        (scl),
        .sda        (sda),
        .refuse     (refuse),
        .sda_low    (sda_low_s),
        .stop_count (stop_count),
        .peek_addr  (peek_addr),
        .peek_data  (peek_data)
    );

    initial
        CLK = 1'b0;
    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles > limit)
        begin
            $display("timeout: tests did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    function automatic logic [7:0] parse_hex(input word_t s);
        int v;
        logic [7:0] c;
        v = 0;
        for (int k = 15; k >= 0; k--)
        begin
            c = s[k*8 +: 8];
            if (c >= 8'h30 && c <= 8'h39)
                v = v * 16 + int'(c - 8'h30);
            else if (c >= 8'h61 && c <= 8'h66)
                v = v * 16 + int'(c - 8'h57);
        end
        return v[7:0];
    endfunction

    task automatic stop_run(input string why);
        $display("%0s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input word_t name, input word_t what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected == actual)
        else
        begin
            $display("** Error %0s: %0s expected %0h, actual %0h", name, what, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_tests();
        int fd;
        int rc;
        int rf;
        logic [8*80-1:0] line;
        word_t nm;
        word_t op;
        word_t ds;
        logic [31:0] a;
        fd = $fopen("tests/eeprom_tests.txt", "r");
        if (fd == 0)
            stop_run("cannot open test file");
        n_tests = 0;
        while (!$feof(fd) && n_tests < 64)
        begin
            line = '0;
            rc = $fgets(line, fd);
            rc = $sscanf(line, "%s %s %h %s %d", nm, op, a, ds, rf);
            if (rc == 5 && nm != W_HASH)
            begin
                t_name[n_tests] = nm;
                t_op[n_tests]   = op;
                t_addr[n_tests] = a[10:0];
                t_lcg[n_tests]  = (ds == W_LCG);
                t_data[n_tests] = parse_hex(ds);
                t_ref[n_tests]  = (rf != 0);
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int i);
        logic [7:0] data_v;
        logic is_read;
        is_read = (t_op[i] == OP_RD);
        if (!is_read && t_op[i] != OP_WR && t_op[i] != OP_WB)
            stop_run("unknown operation");
        data_v = t_lcg[i] ? next_rand() : t_data[i];
        @(posedge CLK);
        #1;
        refuse  = t_ref[i];
        addr    = t_addr[i];
        wr_data = data_v;
        wr      = !is_read;
        rd      = is_read;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        check_value(t_name[i], word_t'("busy"), 32'd1, 32'(busy));
        if (t_op[i] == OP_WB)
        begin
            wr      = 1'b1; // must be dropped
            addr    = t_addr[i] ^ 11'h001;
            wr_data = ~data_v;
            @(posedge CLK);
            #1;
            wr = 1'b0;
        end
        while (!ack)
        begin
            @(posedge CLK);
            #1;
        end
        accepted++;
        check_value(t_name[i], word_t'("error"), 32'(t_ref[i]), 32'(error));
        if (is_read && !t_ref[i])
            check_value(t_name[i], word_t'("rd_data"), 32'(shadow[t_addr[i]]), 32'(rd_data));
        if (!is_read && !t_ref[i])
            shadow[t_addr[i]] = data_v;
        check_value(t_name[i], word_t'("stops"), 32'(accepted), 32'(stop_count));
        refuse = 1'b0;
    endtask

    initial
    begin
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = 11'd0;
        wr_data   = 8'd0;
        refuse    = 1'b0;
        peek_addr = 11'd0;
        cycles    = 0;
        accepted  = 0;
        lcg_state = 32'h2abf_d0b9;
        limit     = 1000;
        for (int a = 0; a < 2048; a++)
            shadow[a] = a[7:0] ^ 8'h5a;
        load_tests();
        limit = n_tests * 40 * 4 * `SCL_QUARTER + 200;
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(posedge CLK);
        #1;
        check_value(word_t'("reset"), word_t'("scl"), 32'd1, 32'(scl));
        check_value(word_t'("reset"), word_t'("sda_low"), 32'd0, 32'(sda_low_m));
        check_value(word_t'("reset"), word_t'("busy"), 32'd0, 32'(busy));
        check_value(word_t'("reset"), word_t'("ack"), 32'd0, 32'(ack));
        for (int i = 0; i < n_tests; i++)
            run_test(i);
        // whole array against the shadow copy
        for (int k = 0; k < 2048; k++)
        begin
            peek_addr = k[10:0];
            #1;
            check_value(word_t'("memory"), word_t'("byte"), 32'(shadow[k]), 32'(peek_data));
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
